// File: hw/eth_stat_pkg.sv
// Counter ids are port times four plus kind and all counters are 32 bits wide and wrap

package eth_stat_pkg;

// Counter slots reserved per port
localparam int STAT_KINDS = 4;

// Counter value and increment amount
typedef logic [31:0] stat_count_t;

// Counter index, port * STAT_KINDS + kind
typedef logic [9:0] stat_id_t;

// Per-port counter kinds
typedef enum logic [1:0] {
    STAT_GOOD     = 2'd0,
    STAT_BYTES    = 2'd1,
    STAT_BAD      = 2'd2,
    // Never incremented, reads as zero
    STAT_RESERVED = 2'd3
} stat_kind_e;

// One counter increment
typedef struct packed {
    stat_id_t    id;
    stat_count_t inc;
} stat_event_t;

// AXI4-Lite bus types
typedef logic [11:0] axil_addr_t;
typedef logic [31:0] axil_data_t;
typedef logic [1:0]  axil_resp_t;

localparam axil_resp_t AXIL_RESP_OKAY   = 2'b00;
localparam axil_resp_t AXIL_RESP_SLVERR = 2'b10;

endpackage

// File: hw/gmii_frame_monitor.sv
// Holds one frame of pending events and drops the events of a frame that ends before they drain
`resetall
`timescale 1ns/1ps
`default_nettype none

module gmii_frame_monitor #(
    // Own port number, selects the counter ids
    parameter int PORT_INDEX = 0
) (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // GMII receive
    input  wire logic [7:0]                 rxd,
    input  wire logic                       rx_dv,
    input  wire logic                       rx_er,

    // GMII transmit, looped back from receive
    output      logic [7:0]                 txd,
    output      logic                       tx_en,
    output      logic                       tx_er,

    // Increment events
    output      eth_stat_pkg::stat_event_t  evt,
    output      logic                       evt_valid,
    input  wire logic                       evt_ready
);

localparam eth_stat_pkg::stat_id_t ID_BASE =
    eth_stat_pkg::stat_id_t'(PORT_INDEX * eth_stat_pkg::STAT_KINDS);

typedef enum logic [1:0] {
    MON_IDLE,
    MON_FRAME_EVT,
    MON_BYTE_EVT
} mon_state_e;

mon_state_e state;

eth_stat_pkg::stat_count_t byte_cnt;
eth_stat_pkg::stat_count_t byte_hold;
logic err_seen;
logic frame_end;

function automatic eth_stat_pkg::stat_id_t kind_id(input eth_stat_pkg::stat_kind_e kind);
    return ID_BASE + eth_stat_pkg::stat_id_t'(kind);
endfunction

// Loopback register, tx_en doubles as the delayed rx_dv
always_ff @(posedge clk) begin
    txd <= rxd;
    if (rst) begin
        tx_en <= 1'b0;
        tx_er <= 1'b0;
    end else begin
        tx_en <= rx_dv;
        tx_er <= rx_er;
    end
end

// Falling edge of rx_dv
assign frame_end = tx_en && !rx_dv;

// Byte count includes preamble and SFD
always_ff @(posedge clk) begin
    if (rx_dv) begin
        if (!tx_en) begin
            byte_cnt <= 32'd1;
            err_seen <= rx_er;
        end else begin
            byte_cnt <= byte_cnt + 32'd1;
            err_seen <= err_seen | rx_er;
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        state <= MON_IDLE;
    end else begin
        case (state)
            MON_IDLE: begin
                if (frame_end) begin
                    state <= MON_FRAME_EVT;
                end
            end
            MON_FRAME_EVT: begin
                if (evt_ready) begin
                    state <= MON_BYTE_EVT;
                end
            end
            MON_BYTE_EVT: begin
                if (evt_ready) begin
                    state <= MON_IDLE;
                end
            end
            default: state <= MON_IDLE;
        endcase
    end
end

// Frame event first, then the byte event
always_ff @(posedge clk) begin
    if (state == MON_IDLE && frame_end) begin
        evt.id <= err_seen ? kind_id(eth_stat_pkg::STAT_BAD) : kind_id(eth_stat_pkg::STAT_GOOD);
        evt.inc <= 32'd1;
        byte_hold <= byte_cnt;
    end else if (state == MON_FRAME_EVT && evt_ready) begin
        evt.id <= kind_id(eth_stat_pkg::STAT_BYTES);
        evt.inc <= byte_hold;
    end
end

assign evt_valid = (state != MON_IDLE);

endmodule

`resetall

// File: hw/stat_arb_mux.sv
// Combinational grant with round-robin priority that advances only after a transfer
`resetall
`timescale 1ns/1ps
`default_nettype none

module stat_arb_mux #(
    parameter int PORTS = 2
) (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // Per-port event streams
    input  wire eth_stat_pkg::stat_event_t  in_evt [PORTS],
    input  wire logic [PORTS-1:0]           in_valid,
    output      logic [PORTS-1:0]           in_ready,

    // Merged stream
    output      eth_stat_pkg::stat_event_t  out_evt,
    output      logic                       out_valid,
    input  wire logic                       out_ready
);

localparam int PTR_W = (PORTS > 1) ? $clog2(PORTS) : 1;

logic [PTR_W-1:0] last_grant;
logic [PTR_W-1:0] grant_idx;
logic grant_valid;

// Search starts one past the last granted port
always_comb begin
    int idx;
    grant_valid = 1'b0;
    grant_idx = last_grant;
    for (int i = 1; i <= PORTS; i++) begin
        idx = (int'(last_grant) + i) % PORTS;
        if (!grant_valid && in_valid[idx]) begin
            grant_valid = 1'b1;
            grant_idx = PTR_W'(idx);
        end
    end
end

assign out_evt = in_evt[grant_idx];
assign out_valid = grant_valid;

// Only the granted port sees the downstream ready
always_comb begin
    for (int p = 0; p < PORTS; p++) begin
        in_ready[p] = grant_valid && out_ready && (grant_idx == PTR_W'(p));
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        last_grant <= PTR_W'(PORTS - 1);
    end else if (grant_valid && out_ready) begin
        last_grant <= grant_idx;
    end
end

endmodule

`resetall

// File: hw/stat_counter_ram.sv
// Ready stays low for PORTS*4 cycles after reset while the counters are zeroed
`resetall
`timescale 1ns/1ps
`default_nettype none

module stat_counter_ram #(
    parameter int PORTS = 2
) (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // Increment stream
    input  wire eth_stat_pkg::stat_event_t  evt,
    input  wire logic                       evt_valid,
    output      logic                       evt_ready,

    // Read port, data one cycle after rd_en
    input  wire logic                       rd_en,
    input  wire eth_stat_pkg::stat_id_t     rd_id,
    output      eth_stat_pkg::stat_count_t  rd_data
);

localparam int DEPTH = PORTS * eth_stat_pkg::STAT_KINDS;
localparam int ADDR_W = $clog2(DEPTH);

typedef logic [ADDR_W-1:0] ram_addr_t;

typedef enum logic {
    RAM_CLEAR,
    RAM_RUN
} ram_state_e;

ram_state_e state;
ram_addr_t clr_addr;

eth_stat_pkg::stat_count_t mem [DEPTH];

ram_addr_t evt_addr;
logic accept;

// Read stage
logic rmw_valid;
ram_addr_t rmw_addr;
eth_stat_pkg::stat_count_t rmw_inc;
eth_stat_pkg::stat_count_t rmw_old;
eth_stat_pkg::stat_count_t rmw_base;

// Write stage
logic wr_valid;
ram_addr_t wr_addr;
eth_stat_pkg::stat_count_t wr_sum;

assign evt_ready = (state == RAM_RUN);
assign accept = evt_valid && evt_ready;
assign evt_addr = evt.id[ADDR_W-1:0];

always_ff @(posedge clk) begin
    if (rst) begin
        state <= RAM_CLEAR;
        clr_addr <= '0;
        rmw_valid <= 1'b0;
        wr_valid <= 1'b0;
    end else begin
        if (state == RAM_CLEAR) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == ram_addr_t'(DEPTH - 1)) begin
                state <= RAM_RUN;
            end
        end
        rmw_valid <= accept;
        wr_valid <= rmw_valid;
    end
end

// Write stage value is newer than the memory, forward it at both hazards
assign rmw_base = (wr_valid && wr_addr == rmw_addr) ? wr_sum : rmw_old;

always_ff @(posedge clk) begin
    rmw_addr <= evt_addr;
    rmw_inc <= evt.inc;
    if (wr_valid && wr_addr == evt_addr) begin
        rmw_old <= wr_sum;
    end else begin
        rmw_old <= mem[evt_addr];
    end
    wr_addr <= rmw_addr;
    wr_sum <= rmw_base + rmw_inc;
end

always_ff @(posedge clk) begin
    if (state == RAM_CLEAR) begin
        mem[clr_addr] <= '0;
    end else if (wr_valid) begin
        mem[wr_addr] <= wr_sum;
    end
end

// Read during a write returns the old value
always_ff @(posedge clk) begin
    if (rd_en) begin
        rd_data <= mem[rd_id[ADDR_W-1:0]];
    end
end

endmodule

`resetall

// File: hw/stat_axil_regs.sv
// Read-only counter window with one read in flight and every write answered with SLVERR
`resetall
`timescale 1ns/1ps
`default_nettype none

module stat_axil_regs #(
    parameter int PORTS = 2
) (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // AXI4-Lite write channels
    input  wire eth_stat_pkg::axil_addr_t   awaddr,
    input  wire logic                       awvalid,
    output      logic                       awready,
    input  wire eth_stat_pkg::axil_data_t   wdata,
    input  wire logic [3:0]                 wstrb,
    input  wire logic                       wvalid,
    output      logic                       wready,
    output      eth_stat_pkg::axil_resp_t   bresp,
    output      logic                       bvalid,
    input  wire logic                       bready,

    // AXI4-Lite read channels
    input  wire eth_stat_pkg::axil_addr_t   araddr,
    input  wire logic                       arvalid,
    output      logic                       arready,
    output      eth_stat_pkg::axil_data_t   rdata,
    output      eth_stat_pkg::axil_resp_t   rresp,
    output      logic                       rvalid,
    input  wire logic                       rready,

    // Counter memory read port
    output      logic                       rd_en,
    output      eth_stat_pkg::stat_id_t     rd_id,
    input  wire eth_stat_pkg::stat_count_t  rd_data
);

localparam eth_stat_pkg::stat_id_t LAST_ID =
    eth_stat_pkg::stat_id_t'(PORTS * eth_stat_pkg::STAT_KINDS - 1);

typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,
    RD_RESP
} rd_state_e;

rd_state_e rd_state;

eth_stat_pkg::stat_id_t ar_id;
logic ar_err;
logic rd_err;
logic wr_accept;

// One 32-bit word per counter, low address bits ignored
assign ar_id = araddr[11:2];
assign ar_err = (ar_id > LAST_ID);

assign arready = (rd_state == RD_IDLE);
assign rvalid = (rd_state == RD_RESP);

// Memory read issued on the address handshake
assign rd_en = arvalid && arready && !ar_err;
assign rd_id = ar_id;

always_ff @(posedge clk) begin
    if (rst) begin
        rd_state <= RD_IDLE;
    end else begin
        case (rd_state)
            RD_IDLE: begin
                if (arvalid) begin
                    rd_state <= RD_WAIT;
                end
            end
            RD_WAIT: rd_state <= RD_RESP;
            RD_RESP: begin
                if (rready) begin
                    rd_state <= RD_IDLE;
                end
            end
            default: rd_state <= RD_IDLE;
        endcase
    end
end

// Response captured once and held through back-pressure
always_ff @(posedge clk) begin
    if (rd_state == RD_IDLE) begin
        rd_err <= ar_err;
    end
    if (rd_state == RD_WAIT) begin
        rdata <= rd_err ? '0 : rd_data;
        rresp <= rd_err ? eth_stat_pkg::AXIL_RESP_SLVERR : eth_stat_pkg::AXIL_RESP_OKAY;
    end
end

// Address and data of a write are taken together and discarded
assign wr_accept = awvalid && wvalid && !bvalid;
assign awready = wr_accept;
assign wready = wr_accept;
assign bresp = eth_stat_pkg::AXIL_RESP_SLVERR;

always_ff @(posedge clk) begin
    if (rst) begin
        bvalid <= 1'b0;
    end else if (wr_accept) begin
        bvalid <= 1'b1;
    end else if (bready) begin
        bvalid <= 1'b0;
    end
end

endmodule

`resetall

// File: hw/eth_stat_core.sv
// Single clock domain with two GMII ports wired to port numbers 0 and 1
`resetall
`timescale 1ns/1ps
`default_nettype none

module eth_stat_core #(
    // Monitored ports
    parameter int PORTS = 2
) (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // GMII port 0
    input  wire logic [7:0]                 gmii0_rxd,
    input  wire logic                       gmii0_rx_dv,
    input  wire logic                       gmii0_rx_er,
    output wire logic [7:0]                 gmii0_txd,
    output wire logic                       gmii0_tx_en,
    output wire logic                       gmii0_tx_er,

    // GMII port 1
    input  wire logic [7:0]                 gmii1_rxd,
    input  wire logic                       gmii1_rx_dv,
    input  wire logic                       gmii1_rx_er,
    output wire logic [7:0]                 gmii1_txd,
    output wire logic                       gmii1_tx_en,
    output wire logic                       gmii1_tx_er,

    // AXI4-Lite slave
    input  wire eth_stat_pkg::axil_addr_t   awaddr,
    input  wire logic                       awvalid,
    output wire logic                       awready,
    input  wire eth_stat_pkg::axil_data_t   wdata,
    input  wire logic [3:0]                 wstrb,
    input  wire logic                       wvalid,
    output wire logic                       wready,
    output wire eth_stat_pkg::axil_resp_t   bresp,
    output wire logic                       bvalid,
    input  wire logic                       bready,
    input  wire eth_stat_pkg::axil_addr_t   araddr,
    input  wire logic                       arvalid,
    output wire logic                       arready,
    output wire eth_stat_pkg::axil_data_t   rdata,
    output wire eth_stat_pkg::axil_resp_t   rresp,
    output wire logic                       rvalid,
    input  wire logic                       rready
);

// Per-port event streams
wire eth_stat_pkg::stat_event_t port_evt [PORTS];
wire logic [PORTS-1:0] port_valid;
wire logic [PORTS-1:0] port_ready;

// Merged event stream
wire eth_stat_pkg::stat_event_t stat_evt;
wire logic stat_valid;
wire logic stat_ready;

// Counter read port
wire logic rd_en;
wire eth_stat_pkg::stat_id_t rd_id;
wire eth_stat_pkg::stat_count_t rd_data;

gmii_frame_monitor #(
    .PORT_INDEX(0)
)
monitor0_inst (
    .clk(clk),
    .rst(rst),
    .rxd(gmii0_rxd),
    .rx_dv(gmii0_rx_dv),
    .rx_er(gmii0_rx_er),
    .txd(gmii0_txd),
    .tx_en(gmii0_tx_en),
    .tx_er(gmii0_tx_er),
    .evt(port_evt[0]),
    .evt_valid(port_valid[0]),
    .evt_ready(port_ready[0])
);

gmii_frame_monitor #(
    .PORT_INDEX(1)
)
monitor1_inst (
    .clk(clk),
    .rst(rst),
    .rxd(gmii1_rxd),
    .rx_dv(gmii1_rx_dv),
    .rx_er(gmii1_rx_er),
    .txd(gmii1_txd),
    .tx_en(gmii1_tx_en),
    .tx_er(gmii1_tx_er),
    .evt(port_evt[1]),
    .evt_valid(port_valid[1]),
    .evt_ready(port_ready[1])
);

stat_arb_mux #(
    .PORTS(PORTS)
)
arb_inst (
    .clk(clk),
    .rst(rst),
    .in_evt(port_evt),
    .in_valid(port_valid),
    .in_ready(port_ready),
    .out_evt(stat_evt),
    .out_valid(stat_valid),
    .out_ready(stat_ready)
);

stat_counter_ram #(
    .PORTS(PORTS)
)
ram_inst (
    .clk(clk),
    .rst(rst),
    .evt(stat_evt),
    .evt_valid(stat_valid),
    .evt_ready(stat_ready),
    .rd_en(rd_en),
    .rd_id(rd_id),
    .rd_data(rd_data)
);

stat_axil_regs #(
    .PORTS(PORTS)
)
regs_inst (
    .clk(clk),
    .rst(rst),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wstrb(wstrb),
    .wvalid(wvalid),
    .wready(wready),
    .bresp(bresp),
    .bvalid(bvalid),
    .bready(bready),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rresp(rresp),
    .rvalid(rvalid),
    .rready(rready),
    .rd_en(rd_en),
    .rd_id(rd_id),
    .rd_data(rd_data)
);

endmodule

`resetall

// File: test/tb_eth_stat_core.sv
// Run from the project root so test/stat_input.txt is found; port 2 in that file drives both ports
`timescale 1ns/1ps

module tb_eth_stat_core;

localparam int CLK_PERIOD = 4;
localparam int IFG = 12;
localparam int PORTS = 2;

logic clk = 1'b0;
logic rst;

// GMII stimulus and loopback outputs
logic [7:0] gmii0_rxd;
logic gmii0_rx_dv;
logic gmii0_rx_er;
logic [7:0] gmii1_rxd;
logic gmii1_rx_dv;
logic gmii1_rx_er;
logic [7:0] gmii0_txd;
logic gmii0_tx_en;
logic gmii0_tx_er;
logic [7:0] gmii1_txd;
logic gmii1_tx_en;
logic gmii1_tx_er;

// AXI4-Lite master side
eth_stat_pkg::axil_addr_t awaddr;
logic awvalid;
logic awready;
eth_stat_pkg::axil_data_t wdata;
logic [3:0] wstrb;
logic wvalid;
logic wready;
eth_stat_pkg::axil_resp_t bresp;
logic bvalid;
logic bready;
eth_stat_pkg::axil_addr_t araddr;
logic arvalid;
logic arready;
eth_stat_pkg::axil_data_t rdata;
eth_stat_pkg::axil_resp_t rresp;
logic rvalid;
logic rready;

// Frame list and expected counters
int frame_port[$];
int frame_len[$];
bit frame_err[$];
logic [31:0] exp_good [PORTS];
logic [31:0] exp_bytes [PORTS];
logic [31:0] exp_bad [PORTS];
logic [31:0] total_frames;
logic [31:0] total_bytes;
logic [31:0] cnt_rd [PORTS*4];
int dual_frames;
int frame_cycles;
int watch_cycles;

int errors;
int tests_run;
int tests_failed;
int lb_errors;
bit lb_armed;
logic [31:0] rng;

// Inputs seen by the DUT at the last edge
logic [7:0] prev0_rxd;
logic prev0_dv;
logic prev0_er;
logic [7:0] prev1_rxd;
logic prev1_dv;
logic prev1_er;

eth_stat_core #(
    .PORTS(PORTS)
) UUT (
    .clk(clk),
    .rst(rst),
    .gmii0_rxd(gmii0_rxd),
    .gmii0_rx_dv(gmii0_rx_dv),
    .gmii0_rx_er(gmii0_rx_er),
    .gmii0_txd(gmii0_txd),
    .gmii0_tx_en(gmii0_tx_en),
    .gmii0_tx_er(gmii0_tx_er),
    .gmii1_rxd(gmii1_rxd),
    .gmii1_rx_dv(gmii1_rx_dv),
    .gmii1_rx_er(gmii1_rx_er),
    .gmii1_txd(gmii1_txd),
    .gmii1_tx_en(gmii1_tx_en),
    .gmii1_tx_er(gmii1_tx_er),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wstrb(wstrb),
    .wvalid(wvalid),
    .wready(wready),
    .bresp(bresp),
    .bvalid(bvalid),
    .bready(bready),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rresp(rresp),
    .rvalid(rvalid),
    .rready(rready)
);

always #(CLK_PERIOD / 2) clk = ~clk;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic bit check_equal(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
    if (got !== exp) begin
        $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got);
        errors++;
        return 1'b0;
    end
    return 1'b1;
endfunction

task automatic finish_test(input string name, input int test_errors);
    tests_run++;
    if (test_errors == 0) begin
        $display("Test %s: passed", name);
    end else begin
        tests_failed++;
        $display("Test %s: failed with %0d errors", name, test_errors);
    end
endtask

task automatic load_frames(output bit ok);
    int fd;
    int n;
    int port;
    int len;
    int err;
    int copies;
    string line;
    ok = 1'b0;
    fd = $fopen("test/stat_input.txt", "r");
    if (fd == 0) begin
        $display("Cannot open test/stat_input.txt for reading");
        return;
    end
    while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] != "#") begin
            n = $sscanf(line, "%d %d %d", port, len, err);
            if (n == 3) begin
                frame_port.push_back(port);
                frame_len.push_back(len);
                frame_err.push_back(err != 0);
                frame_cycles += len + IFG;
                copies = (port == PORTS) ? 2 : 1;
                if (port == PORTS) begin
                    dual_frames++;
                end
                total_frames = total_frames + 32'(copies);
                total_bytes = total_bytes + 32'(copies * len);
                for (int p = 0; p < PORTS; p++) begin
                    if (port == p || port == PORTS) begin
                        if (err != 0) begin
                            exp_bad[p] = exp_bad[p] + 32'd1;
                        end else begin
                            exp_good[p] = exp_good[p] + 32'd1;
                        end
                        exp_bytes[p] = exp_bytes[p] + 32'(len);
                    end
                end
            end
        end
    end
    $fclose(fd);
    ok = (frame_port.size() > 0);
endtask

task automatic set_idle();
    gmii0_rxd = 8'h00;
    gmii0_rx_dv = 1'b0;
    gmii0_rx_er = 1'b0;
    gmii1_rxd = 8'h00;
    gmii1_rx_dv = 1'b0;
    gmii1_rx_er = 1'b0;
endtask

// Port value PORTS starts the frame on both ports in the same cycle
task automatic send_frame(input int port, input int len, input bit err);
    bit on0;
    bit on1;
    on0 = (port == 0) || (port == PORTS);
    on1 = (port == 1) || (port == PORTS);
    for (int i = 0; i < len; i++) begin
        @(posedge clk);
        #1;
        if (on0) begin
            rng = xorshift32(rng);
            gmii0_rxd = rng[7:0];
            gmii0_rx_dv = 1'b1;
            gmii0_rx_er = err && (i == len / 2);
        end
        if (on1) begin
            rng = xorshift32(rng);
            gmii1_rxd = rng[7:0];
            gmii1_rx_dv = 1'b1;
            gmii1_rx_er = err && (i == len / 2);
        end
    end
    @(posedge clk);
    #1;
    set_idle();
    repeat (IFG - 1) @(posedge clk);
endtask

// rready stays low for hold cycles after rvalid is seen
task automatic axil_read(input eth_stat_pkg::axil_addr_t addr, input int hold,
                         output eth_stat_pkg::axil_data_t data,
                         output eth_stat_pkg::axil_resp_t resp);
    @(posedge clk);
    #1;
    araddr = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    for (int i = 0; i < hold; i++) begin
        @(negedge clk);
        if (!rvalid) begin
            $display("rvalid dropped before the handshake, address 0x%h", addr);
            errors++;
        end
        void'(check_equal("rdata under back-pressure", rdata, data));
        void'(check_equal("rresp under back-pressure", 32'(rresp), 32'(resp)));
    end
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
endtask

task automatic axil_write(input eth_stat_pkg::axil_addr_t addr,
                          input eth_stat_pkg::axil_data_t data,
                          output eth_stat_pkg::axil_resp_t resp);
    @(posedge clk);
    #1;
    awaddr = addr;
    wdata = data;
    wstrb = 4'hf;
    awvalid = 1'b1;
    wvalid = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
endtask

always @(posedge clk) begin
    prev0_rxd <= gmii0_rxd;
    prev0_dv <= gmii0_rx_dv;
    prev0_er <= gmii0_rx_er;
    prev1_rxd <= gmii1_rxd;
    prev1_dv <= gmii1_rx_dv;
    prev1_er <= gmii1_rx_er;
end

// Loopback compared halfway through each cycle
always @(negedge clk) begin
    if (lb_armed) begin
        if (!check_equal("gmii0_txd", 32'(gmii0_txd), 32'(prev0_rxd))) lb_errors++;
        if (!check_equal("gmii0_tx_en", 32'(gmii0_tx_en), 32'(prev0_dv))) lb_errors++;
        if (!check_equal("gmii0_tx_er", 32'(gmii0_tx_er), 32'(prev0_er))) lb_errors++;
        if (!check_equal("gmii1_txd", 32'(gmii1_txd), 32'(prev1_rxd))) lb_errors++;
        if (!check_equal("gmii1_tx_en", 32'(gmii1_tx_en), 32'(prev1_dv))) lb_errors++;
        if (!check_equal("gmii1_tx_er", 32'(gmii1_tx_er), 32'(prev1_er))) lb_errors++;
    end
end

initial begin
    wait (watch_cycles > 0);
    #(watch_cycles * CLK_PERIOD);
    $display("Timeout after %0d cycles, the DUT stopped answering", watch_cycles);
    $display("RESULT: FAIL");
    $finish;
end

initial begin
    bit loaded;
    int mark;
    int hold;
    eth_stat_pkg::axil_data_t data;
    eth_stat_pkg::axil_resp_t resp;
    logic [31:0] sum_frames;
    logic [31:0] sum_bytes;
    rst = 1'b1;
    set_idle();
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = 4'h0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    rng = 32'h17bb;
    for (int p = 0; p < PORTS; p++) begin
        exp_good[p] = '0;
        exp_bytes[p] = '0;
        exp_bad[p] = '0;
    end
    total_frames = '0;
    total_bytes = '0;
    load_frames(loaded);
    watch_cycles = frame_cycles + 2000;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    lb_armed = 1'b1;
    // Clear sweep
    repeat (20) @(posedge clk);
    if (!loaded) begin
        $display("No frames could be read from the stimulus file");
        errors++;
    end else begin
        for (int f = 0; f < frame_port.size(); f++) begin
            send_frame(frame_port[f], frame_len[f], frame_err[f]);
        end
        finish_test("loopback", lb_errors);

        mark = errors;
        for (int p = 0; p < PORTS; p++) begin
            for (int k = 0; k < 2; k++) begin
                axil_read(eth_stat_pkg::axil_addr_t'((p * 4 + k) * 4), 0, data, resp);
                cnt_rd[p * 4 + k] = data;
                void'(check_equal($sformatf("rresp port%0d kind%0d", p, k), 32'(resp), 32'd0));
            end
            void'(check_equal($sformatf("rdata port%0d good", p), cnt_rd[p * 4], exp_good[p]));
            void'(check_equal($sformatf("rdata port%0d bytes", p), cnt_rd[p * 4 + 1],
                              exp_bytes[p]));
        end
        finish_test("good frame and byte counters", errors - mark);

        mark = errors;
        for (int p = 0; p < PORTS; p++) begin
            for (int k = 2; k < 4; k++) begin
                axil_read(eth_stat_pkg::axil_addr_t'((p * 4 + k) * 4), 0, data, resp);
                cnt_rd[p * 4 + k] = data;
                void'(check_equal($sformatf("rresp port%0d kind%0d", p, k), 32'(resp), 32'd0));
            end
            void'(check_equal($sformatf("rdata port%0d bad", p), cnt_rd[p * 4 + 2], exp_bad[p]));
            void'(check_equal($sformatf("rdata port%0d reserved", p), cnt_rd[p * 4 + 3], 32'd0));
        end
        finish_test("bad frame counter", errors - mark);

        // Totals over both ports against the raw frame list
        mark = errors;
        if (dual_frames == 0) begin
            $display("The stimulus file holds no frame for both ports at once");
            errors++;
        end
        sum_frames = '0;
        sum_bytes = '0;
        for (int p = 0; p < PORTS; p++) begin
            sum_frames = sum_frames + cnt_rd[p * 4] + cnt_rd[p * 4 + 2];
            sum_bytes = sum_bytes + cnt_rd[p * 4 + 1];
        end
        void'(check_equal("total frames", sum_frames, total_frames));
        void'(check_equal("total bytes", sum_bytes, total_bytes));
        finish_test("both ports at once", errors - mark);

        mark = errors;
        axil_read(eth_stat_pkg::axil_addr_t'(PORTS * 16), 0, data, resp);
        void'(check_equal("rresp past last counter", 32'(resp), 32'h2));
        void'(check_equal("rdata past last counter", data, 32'd0));
        axil_read(12'hffc, 0, data, resp);
        void'(check_equal("rresp at top address", 32'(resp), 32'h2));
        void'(check_equal("rdata at top address", data, 32'd0));
        axil_write(12'h000, 32'hdeadbeef, resp);
        void'(check_equal("bresp", 32'(resp), 32'h2));
        axil_read(12'h000, 0, data, resp);
        void'(check_equal("rresp after write", 32'(resp), 32'd0));
        void'(check_equal("rdata after write", data, exp_good[0]));
        finish_test("bus errors", errors - mark);

        mark = errors;
        for (int p = 0; p < PORTS; p++) begin
            rng = xorshift32(rng);
            hold = 1 + int'(rng[2:0]);
            axil_read(eth_stat_pkg::axil_addr_t'((p * 4 + 1) * 4), hold, data, resp);
            void'(check_equal($sformatf("rdata port%0d bytes held", p), data, exp_bytes[p]));
            void'(check_equal($sformatf("rresp port%0d bytes held", p), 32'(resp), 32'd0));
        end
        finish_test("read back-pressure", errors - mark);
    end
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
        $display("RESULT: PASS");
    end else begin
        $display("RESULT: FAIL");
    end
    $finish;
end

endmodule

// File: test/stat_input.txt
# port length err: port 0 or 1, or 2 to start the frame on both ports in the same cycle
# length counts every byte with rx_dv high including preamble and SFD, err 1 sets rx_er mid-frame
0 72 0
1 72 0
0 80 1
2 72 0
1 100 0
2 64 1
0 9 0
1 150 1
2 90 0
0 68 0
2 120 0
1 72 0
0 200 0
2 72 1
1 81 0
0 73 1
2 16 0
1 64 0
0 128 0
2 72 0
1 12 1
0 99 0
2 84 0

// File: eth_stat_core.f
hw/eth_stat_pkg.sv
hw/gmii_frame_monitor.sv
hw/stat_arb_mux.sv
hw/stat_counter_ram.sv
hw/stat_axil_regs.sv
hw/eth_stat_core.sv
test/tb_eth_stat_core.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f eth_stat_core.f --top-module tb_eth_stat_core \
    -o tb_eth_stat_core > sim.log 2>&1 \
    && ./obj_dir/tb_eth_stat_core >> sim.log 2>&1 \
    || echo "Build or simulation error" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && echo "Simulation failed" && exit 1
grep -q "RESULT: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
